//--- dv/video_trace.txt
# run <cycles> <frame_count at end> <samples>, then per sample: <x> <y> <rgb hex>
# rst <cycles reset_n is held low>
run 1000 1 1
200 1 000000
run 204800 2 5
10 10 000a40
329 10 3f0a40
265 100 ff6440
266 249 00f940
330 10 000000
rst 5
run 6000 1 2
10 10 000a40
50 12 280c40
run 430000 3 2
300 200 22c840
0 0 000000

//--- tb.f
hw/video_pkg.sv
hw/raster_timing.sv
hw/pattern_gen.sv
hw/video_out_stage.sv
hw/video_core.sv
dv/video_sva.sv
dv/video_checker.sv
dv/tb_video.sv

//--- Makefile
# Verilator build and run of the video core testbench

BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_video \
		-Mdir $(BUILD) -o Vtb_video -f tb.f

run: compile
	./$(BUILD)/Vtb_video | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log

//--- dv/tb_video.sv
// testbench top for the video core
// clock, reset, trace reader, DUT, timeout and final summary

`timescale 1ns/10ps
`default_nettype none

module tb_video
    import video_pkg::*;
();

    localparam int max_segs       = 16;
    localparam int max_samples    = 64;
    localparam int timeout_margin = 1000;

    // record keywords as read by %s into 24 bits
    localparam logic [23:0] rec_run     = "run";
    localparam logic [23:0] rec_rst     = "rst";
    localparam logic [23:0] rec_comment = {16'h0000, "#"};

    logic        clk_core_12288;
    logic        reset_n;
    rgb_t        video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        video_skip;
    frame_cnt_t  frame_count;

    // segments and samples as read from the trace
    bit          seg_is_reset [max_segs];
    int          seg_cycles   [max_segs];
    int          seg_frames   [max_segs];
    int          seg_first    [max_segs];
    int          seg_samples  [max_segs];
    int          smp_x        [max_samples];
    int          smp_y        [max_samples];
    logic [23:0] smp_rgb      [max_samples];
    int          num_segs;
    int          num_samples;
    bit          trace_ok;

    int          cycle_count;
    int          cycle_limit;

    video_core uut (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs),
        .video_skip     (video_skip),
        .frame_count    (frame_count)
    );

    video_checker chk (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs),
        .video_skip     (video_skip),
        .frame_count    (frame_count)
    );

    // 40 ns period
    always #20 clk_core_12288 = ~clk_core_12288;

    ////////////////////////////////////////////////////////////////////////////
    // trace reader
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int             fd;
        int             n;
        int             a;
        int             b;
        int             c;
        logic [23:0]    kind;
        logic [23:0]    rgb;
        logic [1023:0]  rest;
        fd = $fopen("dv/video_trace.txt", "r");
        trace_ok = (fd != 0);
        num_segs = 0;
        num_samples = 0;
        while (trace_ok && num_segs < max_segs && $fscanf(fd, "%s", kind) == 1) begin
            if (kind == rec_comment) begin
                // rest of the line is a note
                n = $fgets(rest, fd);
            end else if (kind == rec_run || kind == rec_rst) begin
                b = 0;
                c = 0;
                if (kind == rec_rst) begin
                    n = $fscanf(fd, "%d", a);
                end else begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                end
                seg_is_reset[num_segs] = (kind == rec_rst);
                seg_cycles[num_segs]   = a;
                seg_frames[num_segs]   = b;
                seg_first[num_segs]    = num_samples;
                seg_samples[num_segs]  = c;
                for (int j = 0; j < c && num_samples < max_samples; j++) begin
                    n = $fscanf(fd, "%d %d %h", a, b, rgb);
                    smp_x[num_samples]   = a;
                    smp_y[num_samples]   = b;
                    smp_rgb[num_samples] = rgb;
                    num_samples = num_samples + 1;
                end
                num_segs = num_segs + 1;
            end else begin
                $display("trace file holds a record of unknown kind");
                trace_ok = 1'b0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (num_segs == 0) begin
            trace_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // segment player, reset_n moves 2 ns after the clock edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic play_trace();
        for (int i = 0; i < num_segs; i++) begin
            if (seg_is_reset[i]) begin
                // mid-frame reset pulse
                reset_n = 1'b0;
                repeat (seg_cycles[i]) @(posedge clk_core_12288);
                #2;
                reset_n = 1'b1;
                chk.end_test("reset", seg_cycles[i], 0);
            end else begin
                for (int j = seg_first[i]; j < seg_first[i] + seg_samples[i]; j++) begin
                    chk.add_sample(smp_x[j], smp_y[j], smp_rgb[j]);
                end
                repeat (seg_cycles[i]) @(posedge clk_core_12288);
                #2;
                chk.end_test("run", seg_cycles[i], seg_frames[i]);
            end
        end
    endtask

    // run length guard
    always @(posedge clk_core_12288) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        clk_core_12288 = 1'b0;
        reset_n        = 1'b0;
        cycle_count    = 0;
        load_trace();
        // reset, every segment, and some slack
        cycle_limit = 8 + timeout_margin;
        for (int i = 0; i < num_segs; i++) begin
            cycle_limit = cycle_limit + seg_cycles[i];
        end
        repeat (8) @(posedge clk_core_12288);
        #2;
        reset_n = 1'b1;
        chk.end_test("reset", 8, 0);
        if (trace_ok) begin
            play_trace();
        end else begin
            $display("trace file dv/video_trace.txt could not be read");
        end
        $display("tests %0d, errors %0d", chk.tests, chk.errors);
        if (trace_ok && chk.errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/video_checker.sv
// output checker for the video core
// raster model from the edge count since reset, per-cycle compare of
// every output, trace samples and frame counts at the end of each test

`timescale 1ns/10ps
`default_nettype none

module video_checker
    import video_pkg::*;
(
    input wire              clk_core_12288,
    input wire              reset_n,
    input wire rgb_t        video_rgb,
    input wire              video_de,
    input wire              video_vs,
    input wire              video_hs,
    input wire              video_skip,
    input wire frame_cnt_t  frame_count
);

    localparam int max_pending = 16;
    localparam int print_limit = 20;
    localparam int frame_len   = def_h_total * def_v_total;

    int          errors      = 0;
    int          tests       = 0;
    int          test_errors = 0;
    int          printed     = 0;
    // edges since reset was released
    int          edge_n      = 0;

    // trace samples of the running test
    int          samp_n = 0;
    int          samp_x   [max_pending];
    int          samp_y   [max_pending];
    logic [23:0] samp_rgb [max_pending];
    bit          samp_hit [max_pending];

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors      = errors + 1;
            test_errors = test_errors + 1;
            if (printed < print_limit) begin
                $display("error %s expected %h actual %h at edge %0d",
                         name, expected, actual, edge_n);
            end
            printed = printed + 1;
        end
    endtask

    task automatic add_sample(input int x, input int y, input logic [23:0] rgb);
        if (samp_n < max_pending) begin
            samp_x[samp_n]   = x;
            samp_y[samp_n]   = y;
            samp_rgb[samp_n] = rgb;
            samp_hit[samp_n] = 1'b0;
            samp_n = samp_n + 1;
        end
    endtask

    task automatic end_test(input string kind, input int cycles, input int frames);
        string verdict;
        check_value("frame_count", frames, 32'(frame_count));
        for (int i = 0; i < samp_n; i++) begin
            if (!samp_hit[i]) begin
                $display("sample at x %0d y %0d was never reached", samp_x[i], samp_y[i]);
                errors      = errors + 1;
                test_errors = test_errors + 1;
            end
        end
        if (test_errors == 0) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
        end
        tests = tests + 1;
        $display("test %0d %s of %0d cycles: %0d errors, %s",
                 tests, kind, cycles, test_errors, verdict);
        test_errors = 0;
        samp_n      = 0;
    endtask

    // model restarts with every reset
    always @(posedge clk_core_12288) begin
        if (!reset_n) begin
            edge_n = 0;
        end else begin
            edge_n = edge_n + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare on the falling edge, outputs are settled there
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_core_12288) begin
        int          k;
        int          x;
        int          y;
        logic        exp_de;
        logic        exp_vs;
        logic        exp_hs;
        logic [23:0] exp_rgb;
        int          exp_fc;
        exp_de  = 1'b0;
        exp_vs  = 1'b0;
        exp_hs  = 1'b0;
        exp_rgb = '0;
        exp_fc  = 0;
        if (reset_n && edge_n >= 2) begin
            // outputs after edge n reflect count n - 2
            k = edge_n - 2;
            x = k % def_h_total;
            y = (k / def_h_total) % def_v_total;
            exp_de = (x >= def_h_bporch) && (x < def_h_bporch + def_h_active)
                  && (y >= def_v_bporch) && (y < def_v_bporch + def_v_active);
            exp_vs = (x == 0) && (y == 0);
            exp_hs = (x == def_hs_point);
            if (exp_de) begin
                exp_rgb = {8'(x - def_h_bporch), 8'(y), def_pattern_blue};
            end
            // first frame counted at the origin
            exp_fc = k / frame_len + 1;
            for (int i = 0; i < samp_n; i++) begin
                if (!samp_hit[i] && samp_x[i] == x && samp_y[i] == y) begin
                    samp_hit[i] = 1'b1;
                    check_value("video_rgb sample", 32'(samp_rgb[i]), 32'(video_rgb));
                end
            end
        end
        check_value("video_de", 32'(exp_de), 32'(video_de));
        check_value("video_vs", 32'(exp_vs), 32'(video_vs));
        check_value("video_hs", 32'(exp_hs), 32'(video_hs));
        check_value("video_skip", 32'(1'b0), 32'(video_skip));
        check_value("video_rgb", 32'(exp_rgb), 32'(video_rgb));
        check_value("frame_count", exp_fc, 32'(frame_count));
    end

endmodule

`default_nettype wire

//--- dv/video_sva.sv
// protocol assertions on the video outputs, bound into the output stage
// single-clock sync pulses, black outside enable, skip held low

`timescale 1ns/10ps
`default_nettype none

module video_sva
    import video_pkg::*;
(
    input wire          clk_core_12288,
    input wire          reset_n,
    input wire rgb_t    video_rgb,
    input wire          video_de,
    input wire          video_vs,
    input wire          video_hs,
    input wire          video_skip
);

    // sync pulses last one clock
    vs_single: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        video_vs |=> !video_vs)
        else $error("video_vs stayed high for more than one clock");

    hs_single: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        video_hs |=> !video_hs)
        else $error("video_hs stayed high for more than one clock");

    // hs kept off the vs clock
    sync_apart: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        !(video_vs && video_hs))
        else $error("video_vs and video_hs high together");

    // blanking is black
    rgb_black: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        !video_de |-> (video_rgb == '0))
        else $error("video_rgb not zero while video_de is low");

    skip_low: assert property (@(posedge clk_core_12288) disable iff (!reset_n)
        !video_skip)
        else $error("video_skip went high");

endmodule

bind video_out_stage video_sva u_video_sva (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_vs       (video_vs),
    .video_hs       (video_hs),
    .video_skip     (video_skip)
);

`default_nettype wire

//--- hw/video_core.sv
// video core top level
// raster timing, test pattern and output stage on one pixel clock

`timescale 1ns/10ps
`default_nettype none

module video_core
    import video_pkg::*;
#(
    parameter int h_total  = def_h_total,
    parameter int h_active = def_h_active,
    parameter int h_bporch = def_h_bporch,
    parameter int v_total  = def_v_total,
    parameter int v_active = def_v_active,
    parameter int v_bporch = def_v_bporch,
    parameter int hs_point = def_hs_point
) (
    input  wire         clk_core_12288,
    input  wire         reset_n,
    output rgb_t        video_rgb,
    output logic        video_de,
    output logic        video_vs,
    output logic        video_hs,
    output logic        video_skip,
    output frame_cnt_t  frame_count
);

    // raster position and decode
    logic [coord_w-1:0] x_count;
    h_phase_e           phase;
    logic               v_in_active;
    logic               frame_start;

    // pattern pixel for the current count
    rgb_t               pixel;

    raster_timing #(
        .h_total  (h_total),
        .h_active (h_active),
        .h_bporch (h_bporch),
        .v_total  (v_total),
        .v_active (v_active),
        .v_bporch (v_bporch)
    ) u_raster_timing (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .x_count        (x_count),
        .y_count        (),
        .phase          (phase),
        .v_in_active    (v_in_active),
        .frame_start    (frame_start)
    );

    pattern_gen #(
        .pattern_blue (def_pattern_blue)
    ) u_pattern_gen (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .phase          (phase),
        .frame_start    (frame_start),
        .pixel          (pixel)
    );

    video_out_stage #(
        .hs_point (hs_point)
    ) u_video_out_stage (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .x_count        (x_count),
        .phase          (phase),
        .v_in_active    (v_in_active),
        .frame_start    (frame_start),
        .pixel          (pixel),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs),
        .video_skip     (video_skip),
        .frame_count    (frame_count)
    );

endmodule

`default_nettype wire

//--- hw/video_out_stage.sv
// registered video outputs
// data enable, colour with black outside the active window,
// vertical and horizontal sync pulses, skip and the frame counter

`timescale 1ns/10ps
`default_nettype none

module video_out_stage
    import video_pkg::*;
#(
    parameter int hs_point = def_hs_point
) (
    input  wire                 clk_core_12288,
    input  wire                 reset_n,
    input  wire [coord_w-1:0]   x_count,
    input  wire h_phase_e       phase,
    input  wire                 v_in_active,
    input  wire                 frame_start,
    input  wire rgb_t           pixel,
    output rgb_t                video_rgb,
    output logic                video_de,
    output logic                video_vs,
    output logic                video_hs,
    output logic                video_skip,
    output frame_cnt_t          frame_count
);

    localparam logic [coord_w-1:0] hs_x = coord_w'(hs_point);

    logic de_next;

    // visible only inside both the active columns and the active rows
    assign de_next = (phase == h_active) && v_in_active;

    ////////////////////////////////////////////////////////////////////////////
    // output registers, one clock behind the raster count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb   <= '0;
            video_de    <= 1'b0;
            video_vs    <= 1'b0;
            video_hs    <= 1'b0;
            video_skip  <= 1'b0;
            frame_count <= '0;
        end else begin
            video_de   <= de_next;
            // blanking is black
            video_rgb  <= de_next ? pixel : '0;
            // vs in the back porch at the origin
            video_vs   <= frame_start;
            // hs a few clocks later on every line
            video_hs   <= (x_count == hs_x);
            // every frame is shown
            video_skip <= 1'b0;
            if (frame_start) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pattern_gen.sv
// gradient test pattern
// column and row counters driven by the horizontal phase,
// red from the column, green from the row, constant blue

`timescale 1ns/10ps
`default_nettype none

module pattern_gen
    import video_pkg::*;
#(
    parameter logic [7:0] pattern_blue = def_pattern_blue
) (
    input  wire             clk_core_12288,
    input  wire             reset_n,
    input  wire h_phase_e   phase,
    input  wire             frame_start,
    output rgb_t            pixel
);

    // 8 bits is enough, red wraps every 256 columns
    logic [7:0] col_count;
    logic [7:0] row_count;

    // phase of the previous count, to spot the end of the active span
    h_phase_e   phase_q;
    logic       line_end;

    // last active column was the count before this one
    assign line_end = (phase_q == h_active) && (phase != h_active);

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            phase_q   <= h_porch;
            col_count <= '0;
            row_count <= '0;
        end else begin
            phase_q <= phase;
            if (frame_start) begin
                // new frame, back to the top left corner
                col_count <= '0;
                row_count <= '0;
            end else begin
                // column runs through the active span, idles at 0 elsewhere
                if (phase == h_active) begin
                    col_count <= col_count + 1'b1;
                end else begin
                    col_count <= '0;
                end
                // one row per line, blank lines included, so row tracks y
                if (line_end) begin
                    row_count <= row_count + 1'b1;
                end
            end
        end
    end

    assign pixel.red   = col_count;
    assign pixel.green = row_count;
    assign pixel.blue  = pattern_blue;

endmodule

`default_nettype wire

//--- hw/raster_timing.sv
// raster position counters for the video core
// x and y counters with wrap, horizontal phase decode,
// active-row flag and frame start at the origin

`timescale 1ns/10ps
`default_nettype none

module raster_timing
    import video_pkg::*;
#(
    parameter int h_total  = def_h_total,
    parameter int h_active = def_h_active,
    parameter int h_bporch = def_h_bporch,
    parameter int v_total  = def_v_total,
    parameter int v_active = def_v_active,
    parameter int v_bporch = def_v_bporch
) (
    input  wire                 clk_core_12288,
    input  wire                 reset_n,
    output logic [coord_w-1:0]  x_count,
    output logic [coord_w-1:0]  y_count,
    output h_phase_e            phase,
    output logic                v_in_active,
    output logic                frame_start
);

    // last count of each axis
    localparam logic [coord_w-1:0] x_last = coord_w'(h_total - 1);
    localparam logic [coord_w-1:0] y_last = coord_w'(v_total - 1);

    // active window bounds, upper bound exclusive
    localparam logic [coord_w-1:0] x_act_lo = coord_w'(h_bporch);
    localparam logic [coord_w-1:0] x_act_hi = coord_w'(h_bporch + h_active);
    localparam logic [coord_w-1:0] y_act_lo = coord_w'(v_bporch);
    localparam logic [coord_w-1:0] y_act_hi = coord_w'(v_bporch + v_active);

    // first edge after reset only arms the counters
    // so count 0 is the value held after that edge
    logic count_run;

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            count_run <= 1'b0;
            x_count   <= '0;
            y_count   <= '0;
        end else begin
            count_run <= 1'b1;
            if (count_run) begin
                if (x_count == x_last) begin
                    // line wrap, step y
                    x_count <= '0;
                    if (y_count == y_last) begin
                        y_count <= '0;
                    end else begin
                        y_count <= y_count + 1'b1;
                    end
                end else begin
                    x_count <= x_count + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////////////////////

    // the h_active parameter hides the enum literal, so name it through the package
    always_comb begin
        if (x_count < x_act_lo) begin
            phase = h_porch;
        end else if (x_count < x_act_hi) begin
            phase = video_pkg::h_active;
        end else begin
            phase = h_tail;
        end
    end

    assign v_in_active = (y_count >= y_act_lo) && (y_count < y_act_hi);

    // origin of the raster, held off until the counters run
    assign frame_start = count_run && (x_count == '0) && (y_count == '0);

endmodule

`default_nettype wire

//--- hw/video_pkg.sv
// shared definitions for the video core
// raster geometry defaults, counter widths, pixel and frame counter types,
// horizontal phase enum

`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and types
    ////////////////////////////////////////////////////////////////////////////

    // x and y counters, enough for 512 lines
    localparam int coord_w = 10;

    // red in the top byte, blue in the bottom byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [15:0] frame_cnt_t;

    // horizontal region of the current x count
    typedef enum logic [1:0] {
        h_porch,
        h_active,
        h_tail
    } h_phase_e;

    ////////////////////////////////////////////////////////////////////////////
    // default geometry, 320x240 visible in a 400x512 raster
    ////////////////////////////////////////////////////////////////////////////

    // 400 * 512 = 204800 clocks per frame, 60 Hz at 12.288 MHz
    localparam int def_h_total  = 400;
    localparam int def_h_active = 320;
    localparam int def_h_bporch = 10;
    localparam int def_v_total  = 512;
    localparam int def_v_active = 240;
    localparam int def_v_bporch = 10;

    // hs a few clocks into the line, never on the vs cycle
    localparam int def_hs_point = 3;

    localparam logic [7:0] def_pattern_blue = 8'd64;

endpackage

`default_nettype wire
